// ==== verilog/snd_defines.svh ====
/*
    Sound board constants
    Bus widths, scratch RAM size, memory map codes and mixer scaling
*/
`ifndef SND_DEFINES_SVH
`define SND_DEFINES_SVH

`define SND_AW          16      // APB address
`define SND_DW          8       // APB data
`define SND_RAM_AW      8       // 256 byte scratch RAM

// Region codes in paddr[15:13]
`define SND_REG_ROM     3'd0    // ROM also answers on code 1
`define SND_REG_RAM     3'd2
`define SND_REG_LATCH   3'd3
`define SND_REG_TIMER   3'd4
`define SND_REG_PSGDATA 3'd5
`define SND_REG_PSGSEL  3'd6
`define SND_REG_IO      3'd7

// I/O sub-addresses in paddr[2:0]
`define SND_IO_RDAC     3'd0
`define SND_IO_CAP      3'd1
`define SND_IO_STAT     3'd2
`define SND_IO_CTRL     3'd3
`define SND_IO_PCMPG    3'd4

`define SND_TONE_SH     3       // Mixer left shifts
`define SND_PCM_SH      4
`define SND_RDAC_SH     6

`define SND_PCM_END     8'h80   // Stops sample playback

`endif

// ==== verilog/snd_pkg.sv ====
/*
    Sound board types
    Two views of the bus address and the tone register indices
*/
package snd_pkg;

    // Plain memory map view
    typedef struct packed {
        logic [2:0] region;     // Selects the block
        logic [9:0] middle;
        logic [2:0] sub;        // I/O register within region 7
    } snd_map_t;

    // Control writes carry their value in the address
    typedef struct packed {
        logic [2:0] region;
        logic [2:0] spare;
        logic [2:0] ctrl;       // PCM reset, start, rate select
        logic [3:0] cap;        // Filter enables
        logic [2:0] sub;
    } snd_ctrl_t;

    typedef union packed {
        snd_map_t  map;
        snd_ctrl_t ctl;
    } snd_addr_u;

    typedef enum logic [3:0] {
        TONE_P0L = 4'd0,        // Period low/high pairs
        TONE_P0H = 4'd1,
        TONE_P1L = 4'd2,
        TONE_P1H = 4'd3,
        TONE_P2L = 4'd4,
        TONE_P2H = 4'd5,
        TONE_V0  = 4'd6,        // 4-bit volumes
        TONE_V1  = 4'd7,
        TONE_V2  = 4'd8
    } tone_reg_e;

endpackage

// ==== verilog/snd_decode.sv ====
/*
    Sound CPU bus decoder
    APB completer with the memory map: ROM port, scratch RAM, command
    latch, free-running timer, tone register access and I/O controls.
    Every access takes one wait state, ROM accesses also wait on rom_ok
*/
`include "snd_defines.svh"

module snd_decode(
    input                          clk,
    input                          rst,
    // APB completer
    input                          psel,
    input                          penable,
    input                          pwrite,
    input        [`SND_AW-1:0]     paddr,
    input        [`SND_DW-1:0]     pwdata,
    output logic [`SND_DW-1:0]     prdata,
    output logic                   pready,
    output logic                   pslverr,
    // Program ROM
    output       [13:0]            rom_addr,
    output logic                   rom_cs,
    input        [`SND_DW-1:0]     rom_data,
    input                          rom_ok,
    // From main CPU
    input        [`SND_DW-1:0]     main_dout,
    input                          m2s_data,
    // Tone generator
    output                         tone_we,
    output snd_pkg::tone_reg_e     tone_idx,
    output       [`SND_DW-1:0]     tone_din,
    // PCM and mixer
    input                          pcm_busy,
    output logic [3:0]             cap_en,
    output logic                   pcm_rst,
    output logic                   pcm_start,
    output logic                   pcm_sel,
    output logic [7:0]             pcm_page,
    output logic signed [7:0]      rdac
);
    import snd_pkg::*;

    localparam int CNTW = 13;

    snd_addr_u              addr;
    logic [12:0]            loc;        // Offset inside a region
    logic [`SND_RAM_AW-1:0] ram_a;
    logic [`SND_DW-1:0]     ram [0:2**`SND_RAM_AW-1];
    logic [`SND_DW-1:0]     latch;
    logic [CNTW-1:0]        cnt;
    logic [`SND_DW-1:0]     rd_mux;
    tone_reg_e              tone_sel;
    logic                   ram_cs, latch_cs, cnt_cs, psgdata_cs, psgsel_cs;
    logic                   rdac_cs, cap_cs, stat_cs, ctrl_cs, pcmpg_cs;
    logic                   access, done, wr, bad_wr;

    assign addr     = paddr;
    assign loc      = {addr.map.middle, addr.map.sub};
    assign rom_addr = {addr.map.region[0], loc};
    assign ram_a    = loc[`SND_RAM_AW-1:0];     // RAM mirrors across region

    always_comb begin
        rom_cs     = 0;
        ram_cs     = 0;
        latch_cs   = 0;
        cnt_cs     = 0;
        psgdata_cs = 0;
        psgsel_cs  = 0;
        rdac_cs    = 0;
        cap_cs     = 0;
        stat_cs    = 0;
        ctrl_cs    = 0;
        pcmpg_cs   = 0;
        if (psel) begin
            case (addr.map.region)
                `SND_REG_ROM, `SND_REG_ROM + 3'd1: rom_cs = 1;   // 0000-3FFF
                `SND_REG_RAM:     ram_cs     = 1;                 // 4000
                `SND_REG_LATCH:   latch_cs   = 1;                 // 6000
                `SND_REG_TIMER:   cnt_cs     = 1;                 // 8000
                `SND_REG_PSGDATA: psgdata_cs = 1;                 // A000
                `SND_REG_PSGSEL:  psgsel_cs  = 1;                 // C000
                `SND_REG_IO: begin                                // E000
                    case (addr.map.sub)
                        `SND_IO_RDAC:  rdac_cs  = 1;
                        `SND_IO_CAP:   cap_cs   = 1;
                        `SND_IO_STAT:  stat_cs  = 1;
                        `SND_IO_CTRL:  ctrl_cs  = 1;
                        `SND_IO_PCMPG: pcmpg_cs = 1;
                        default: ;
                    endcase
                end
                default: ;
            endcase
        end
    end

    // Handshake
    assign access = psel & penable & ~pready;
    assign done   = access & (~rom_cs | rom_ok);      // pready next cycle
    assign wr     = psel & penable & pwrite & pready;
    assign bad_wr = pwrite & (rom_cs | latch_cs | cnt_cs | stat_cs);

    always_comb begin
        rd_mux = 8'hff;                                   // Unmapped
        if (rom_cs) rd_mux = rom_data;
        else if (ram_cs) rd_mux = ram[ram_a];
        else if (latch_cs) rd_mux = latch;
        else if (cnt_cs) rd_mux = {4'hf, cnt[CNTW-1:CNTW-4]};
        else if (stat_cs) rd_mux = {3'b111, pcm_busy, 4'hf};
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            pready  <= 0;
            pslverr <= 0;
        end else begin
            pready  <= done;
            pslverr <= done & bad_wr;                     // Read-only targets
        end
    end

    always_ff @(posedge clk) begin
        if (done) prdata <= rd_mux;
        if (wr && ram_cs) ram[ram_a] <= pwdata;
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            latch <= 0;
            cnt   <= 0;
        end else begin
            cnt <= cnt + 1'd1;                            // Free running
            if (m2s_data) latch <= main_dout;
        end
    end

    // Control block, CAP and CTRL values come from the address
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            cap_en    <= 0;
            pcm_rst   <= 1;                               // Player held idle
            pcm_start <= 0;
            pcm_sel   <= 0;
            pcm_page  <= 0;
            rdac      <= 0;
            tone_sel  <= TONE_P0L;
        end else begin
            pcm_start <= 0;
            if (wr) begin
                if (cap_cs) cap_en <= addr.ctl.cap;
                if (ctrl_cs) {pcm_rst, pcm_start, pcm_sel} <= addr.ctl.ctrl;
                if (pcmpg_cs) pcm_page <= pwdata;
                if (rdac_cs) rdac <= pwdata;
                if (psgsel_cs) tone_sel <= tone_reg_e'(pwdata[3:0]);
            end
        end
    end

    assign tone_we  = wr & psgdata_cs;
    assign tone_idx = tone_sel;
    assign tone_din = pwdata;

endmodule

// ==== verilog/snd_tone.sv ====
/*
    Three-channel square tone generator
    Each channel toggles after its 10-bit period in psg_cen steps and
    contributes plus or minus its volume times 16 to the output
*/
`include "snd_defines.svh"

module snd_tone(
    input                          clk,
    input                          rst,
    input                          psg_cen,
    // Register writes
    input                          we,
    input  snd_pkg::tone_reg_e     idx,
    input        [`SND_DW-1:0]     din,
    output logic signed [10:0]     tone
);
    import snd_pkg::*;

    logic [9:0]         period [0:2];
    logic [3:0]         vol    [0:2];
    logic [9:0]         cnt    [0:2];
    logic [2:0]         sq;                 // Square level per channel
    logic signed [10:0] sum;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 3; i++) begin
                period[i] <= '0;
                vol[i]    <= '0;
            end
        end else if (we) begin
            case (idx)
                TONE_P0L: period[0][7:0] <= din;
                TONE_P0H: period[0][9:8] <= din[1:0];
                TONE_P1L: period[1][7:0] <= din;
                TONE_P1H: period[1][9:8] <= din[1:0];
                TONE_P2L: period[2][7:0] <= din;
                TONE_P2H: period[2][9:8] <= din[1:0];
                TONE_V0:  vol[0] <= din[3:0];
                TONE_V1:  vol[1] <= din[3:0];
                TONE_V2:  vol[2] <= din[3:0];
                default: ;                  // Indices 9-15 ignored
            endcase
        end
    end

    // Period counters
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 3; i++) begin
                cnt[i] <= '0;
            end
            sq <= '0;
        end else if (psg_cen) begin
            for (int i = 0; i < 3; i++) begin
                if (period[i] == '0) begin
                    cnt[i] <= '0;           // Channel stopped, level kept
                end else if (cnt[i] >= period[i] - 10'd1) begin
                    cnt[i] <= '0;
                    sq[i]  <= ~sq[i];
                end else begin
                    cnt[i] <= cnt[i] + 10'd1;
                end
            end
        end
    end

    // Volume times 16, sign from the square level
    always_comb begin
        sum = '0;
        for (int i = 0; i < 3; i++) begin
            if (sq[i])
                sum = sum + $signed({3'd0, vol[i], 4'd0});
            else
                sum = sum - $signed({3'd0, vol[i], 4'd0});
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) tone <= '0;
        else tone <= sum;                   // Max 3 x 240 fits 11 bits
    end

endmodule

// ==== verilog/snd_pcm.sv ====
/*
    PCM sample player
    Steps through the sample ROM from the start of a page at pcm_cen
    rate, or half of it, until the 0x80 end marker. The last sample holds
*/
`include "snd_defines.svh"

module snd_pcm(
    input                      clk,
    input                      rst,
    input                      pcm_cen,
    // Control from decoder
    input                      pcm_rst,
    input                      start,
    input                      sel,        // Half rate
    input        [7:0]         page,
    // Sample ROM
    output logic [15:0]        pcm_addr,
    output logic               pcm_cs,
    input        [7:0]         pcm_data,
    input                      pcm_ok,
    output logic               busy,
    output logic signed [9:0]  pcm
);
    logic div;          // Rate divider phase
    logic tick;         // Time for the next sample
    logic last;

    assign tick = pcm_cen & (~sel | div);
    assign last = pcm_data == `SND_PCM_END;

    // busy low: idle
    // busy high, pcm_cs low: waiting for a tick
    // busy high, pcm_cs high: fetch in flight
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            busy     <= 0;
            pcm_cs   <= 0;
            div      <= 0;
            pcm_addr <= '0;
            pcm      <= '0;
        end else if (pcm_rst) begin
            busy   <= 0;                    // Forced idle
            pcm_cs <= 0;
            div    <= 0;
        end else if (start) begin
            pcm_addr <= {page, 8'd0};
            busy     <= 1;
            pcm_cs   <= 0;
            div      <= 0;
        end else if (busy) begin
            if (pcm_cen) div <= ~div;
            if (pcm_cs) begin
                if (pcm_ok) begin
                    pcm_cs <= 0;
                    if (last) begin
                        busy <= 0;          // Output keeps last sample
                    end else begin
                        pcm      <= {pcm_data, 2'b00};   // Signed byte x4
                        pcm_addr <= pcm_addr + 16'd1;
                    end
                end
            end else if (tick) begin
                pcm_cs <= 1;                // Request byte at pcm_addr
            end
        end
    end

endmodule

// ==== verilog/snd_mix.sv ====
/*
    Sound mixer
    Gates tone, PCM and raw DAC with the filter enables, scales and
    saturates the sum, then applies an optional one-pole low-pass
*/
`include "snd_defines.svh"

module snd_mix(
    input                       clk,
    input                       rst,
    input  signed [10:0]        tone,
    input  signed [9:0]         pcm,
    input  signed [7:0]         rdac,
    input         [3:0]         cap_en,
    output logic signed [15:0]  snd
);
    logic signed [17:0] tone_s;
    logic signed [17:0] pcm_s;
    logic signed [17:0] rdac_s;
    logic signed [17:0] raw;
    logic signed [15:0] sat;
    logic signed [16:0] diff;
    logic signed [16:0] step;
    logic signed [16:0] nxt;

    always_comb begin
        tone_s = '0;
        pcm_s  = '0;
        rdac_s = '0;
        if (cap_en[0]) tone_s = tone;     // Sign extended
        if (cap_en[1]) pcm_s  = pcm;
        if (cap_en[2]) rdac_s = rdac;
        raw = (tone_s <<< `SND_TONE_SH) + (pcm_s <<< `SND_PCM_SH)
            + (rdac_s <<< `SND_RDAC_SH);
        if (raw > 18'sd32767)
            sat = 16'sh7fff;
        else if (raw < -18'sd32768)
            sat = 16'sh8000;
        else
            sat = raw[15:0];
        diff = sat - snd;
        step = diff >>> 2;                // Quarter of the gap
        nxt  = snd + step;
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) snd <= '0;
        else if (!cap_en[3]) snd <= sat;  // Filter bypassed
        else if (step == '0) snd <= sat;  // Gap under 4 would never close
        else snd <= nxt[15:0];
    end

endmodule

// ==== verilog/snd_top.sv ====
/*
    Arcade sound board
    APB sound register block with a square tone generator, a PCM sample
    player and the output mixer
*/
`include "snd_defines.svh"

module snd_top(
    input                        clk,
    input                        rst,
    input                        psg_cen,
    input                        pcm_cen,
    // APB
    input                        psel,
    input                        penable,
    input                        pwrite,
    input        [`SND_AW-1:0]   paddr,
    input        [`SND_DW-1:0]   pwdata,
    output       [`SND_DW-1:0]   prdata,
    output                       pready,
    output                       pslverr,
    // Program ROM
    output       [13:0]          rom_addr,
    output                       rom_cs,
    input        [`SND_DW-1:0]   rom_data,
    input                        rom_ok,
    // From main CPU
    input        [`SND_DW-1:0]   main_dout,
    input                        m2s_data,
    // Sample ROM
    output       [15:0]          pcm_addr,
    output                       pcm_cs,
    input        [7:0]           pcm_data,
    input                        pcm_ok,
    output signed [15:0]         snd
);
    import snd_pkg::*;

    logic               tone_we;
    tone_reg_e          tone_idx;
    logic [`SND_DW-1:0] tone_din;
    logic [3:0]         cap_en;
    logic               pcm_rst;
    logic               pcm_start;
    logic               pcm_sel;
    logic [7:0]         pcm_page;
    logic               pcm_busy;
    logic signed [7:0]  rdac;
    logic signed [10:0] tone;
    logic signed [9:0]  pcm;

    snd_decode u_decode(
        .clk       ( clk       ), .rst      ( rst       ),
        .psel      ( psel      ), .penable  ( penable   ),
        .pwrite    ( pwrite    ), .paddr    ( paddr     ),
        .pwdata    ( pwdata    ), .prdata   ( prdata    ),
        .pready    ( pready    ), .pslverr  ( pslverr   ),
        .rom_addr  ( rom_addr  ), .rom_cs   ( rom_cs    ),
        .rom_data  ( rom_data  ), .rom_ok   ( rom_ok    ),
        .main_dout ( main_dout ), .m2s_data ( m2s_data  ),
        .tone_we   ( tone_we   ), .tone_idx ( tone_idx  ),
        .tone_din  ( tone_din  ), .pcm_busy ( pcm_busy  ),
        .cap_en    ( cap_en    ), .pcm_rst  ( pcm_rst   ),
        .pcm_start ( pcm_start ), .pcm_sel  ( pcm_sel   ),
        .pcm_page  ( pcm_page  ), .rdac     ( rdac      )
    );

    snd_tone u_tone(
        .clk     ( clk      ), .rst ( rst      ),
        .psg_cen ( psg_cen  ), .we  ( tone_we  ),
        .idx     ( tone_idx ), .din ( tone_din ),
        .tone    ( tone     )
    );

    snd_pcm u_pcm(
        .clk      ( clk       ), .rst      ( rst      ),
        .pcm_cen  ( pcm_cen   ), .pcm_rst  ( pcm_rst  ),
        .start    ( pcm_start ), .sel      ( pcm_sel  ),
        .page     ( pcm_page  ), .pcm_addr ( pcm_addr ),
        .pcm_cs   ( pcm_cs    ), .pcm_data ( pcm_data ),
        .pcm_ok   ( pcm_ok    ), .busy     ( pcm_busy ),
        .pcm      ( pcm       )
    );

    snd_mix u_mix(
        .clk    ( clk    ), .rst    ( rst    ),
        .tone   ( tone   ), .pcm    ( pcm    ),
        .rdac   ( rdac   ), .cap_en ( cap_en ),
        .snd    ( snd    )
    );

endmodule

// ==== tb/snd_tb.sv ====
/*
    Sound board testbench
    Drives APB, program ROM and sample ROM ports of the sound board and
    checks memory map, tone, PCM and mixer behavior with assertions
*/
`include "snd_defines.svh"

module snd_tb;
    localparam int SAMP_LEN = 24;                   // Bytes before the end marker
    localparam int N_XFER   = 60 + SAMP_LEN * 2;    // Status polls included
    localparam int XFER_CYC = 8;                    // Idle, setup, access and ROM wait
    localparam int WD_CYC   = 2 * (N_XFER * XFER_CYC + 10 * 5 * 4 + SAMP_LEN * 8 + 200);

    logic                clk = 0;
    logic                rst;
    logic                psg_cen = 0;
    logic                pcm_cen = 0;
    logic                psel, penable, pwrite;
    logic [`SND_AW-1:0]  paddr;
    logic [`SND_DW-1:0]  pwdata, prdata, main_dout;
    logic                pready, pslverr, m2s_data;
    logic [13:0]         rom_addr;
    logic                rom_cs;
    logic [`SND_DW-1:0]  rom_data = 0;
    logic                rom_ok = 0;
    logic [15:0]         pcm_addr;
    logic                pcm_cs;
    logic [7:0]          pcm_data = 0;
    logic                pcm_ok = 0;
    logic signed [15:0]  snd;

    logic [31:0]         rng = 32'd52810;           // Stimulus stream
    logic [31:0]         rom_rng = 32'd52810;       // ROM latency stream
    logic [31:0]         smp_rng = 32'd52810;       // Sample ROM latency stream
    logic [2:0]          div = 0;
    logic [7:0]          srom [0:65535];
    logic [7:0]          exp_samp [$];              // Expected PCM bytes in order
    logic signed [15:0]  seen [$];                  // snd values during playback
    logic signed [15:0]  mon_prev = 0;
    logic                pcm_mon = 0;

    snd_top i_snd_top(.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        div     <= div + 3'd1;
        psg_cen <= div[1:0] == 2'd3;                // Every 4 clocks
        pcm_cen <= div == 3'd7;                     // Every 8 clocks
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [7:0] rand_byte();
        rng = xorshift32(rng);
        return rng[7:0];
    endfunction

    // Program ROM, low address byte XOR high byte after a random wait
    logic [1:0] rom_dly;
    logic       rom_arm = 0;
    always @(posedge clk) begin
        if (!rom_cs) begin
            rom_ok  <= 0;
            rom_arm <= 0;
        end else if (!rom_arm) begin
            rom_arm <= 1;
            rom_rng <= xorshift32(rom_rng);
            rom_dly <= rom_rng[1:0];                // 0 to 3 extra clocks
        end else if (rom_dly != 0) begin
            rom_dly <= rom_dly - 2'd1;
        end else begin
            rom_ok   <= 1;
            rom_data <= rom_addr[7:0] ^ {2'b00, rom_addr[13:8]};
        end
    end

    // Sample ROM, pcm_ok is a one-clock pulse
    logic [1:0] pcm_dly;
    logic       pcm_arm = 0;
    always @(posedge clk) begin
        if (pcm_ok || !pcm_cs) begin
            pcm_ok  <= 0;
            pcm_arm <= 0;
        end else if (!pcm_arm) begin
            pcm_arm <= 1;
            smp_rng <= xorshift32(smp_rng);
            pcm_dly <= smp_rng[1:0];
        end else if (pcm_dly != 0) begin
            pcm_dly <= pcm_dly - 2'd1;
        end else begin
            pcm_ok   <= 1;
            pcm_data <= srom[pcm_addr];
        end
    end

    initial begin
        for (int a = 0; a < 65536; a++) srom[a] = a[7:0] ^ a[15:8] ^ 8'h3c;
    end

    // Collects each new snd value while a sample plays
    always @(posedge clk) begin
        if (pcm_mon && snd != mon_prev) seen.push_back(snd);
        mon_prev = snd;
    end

    task automatic report_error(input string msg);
        $display("ERR %0t: %s", $time, msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    // Bus strobes
    assert property (@(posedge clk) disable iff (rst) !(pready && $past(pready)))
        else report_error("pready high for two cycles in a row");

    initial begin
        repeat (WD_CYC) @(posedge clk);
        $display("Timeout: the run hung, the sound board stopped answering");
        $display("Simulation failed");
        $fatal(1);
    end

    // One APB transfer, returns at the edge that ends the access phase
    task automatic apb_xfer(input logic wr, input logic [15:0] a, input logic [7:0] d,
                            output logic [7:0] rd, output logic err);
        @(posedge clk);
        psel    <= 1;
        penable <= 0;
        pwrite  <= wr;
        paddr   <= a;
        pwdata  <= d;
        @(posedge clk);
        penable <= 1;
        do @(posedge clk); while (!pready);
        rd      = prdata;
        err     = pslverr;
        psel    <= 0;
        penable <= 0;
    endtask

    task automatic write_reg(input logic [15:0] a, input logic [7:0] d);
        logic [7:0] rd;
        logic       err;
        apb_xfer(1, a, d, rd, err);
        assert (!err) else report_error($sformatf("pslverr on write to %h", a));
    endtask

    task automatic read_reg(input logic [15:0] a, output logic [7:0] rd);
        logic err;
        apb_xfer(0, a, 8'h00, rd, err);
        assert (!err) else report_error($sformatf("pslverr on read of %h", a));
    endtask

    task automatic read_check(input logic [15:0] a, input logic [7:0] exp);
        logic [7:0] rd;
        read_reg(a, rd);
        assert (rd == exp)
            else report_error($sformatf("read %h gave %h, expected %h", a, rd, exp));
    endtask

    task automatic check_snd(input int exp, input string what);
        assert (snd == exp)
            else report_error($sformatf("%s: snd %0d, expected %0d", what, snd, exp));
    endtask

    // I/O address, control values ride in the address bits
    function automatic logic [15:0] io_addr(input logic [2:0] ctrl, input logic [3:0] cap,
                                            input logic [2:0] sub);
        return {`SND_REG_IO, 3'b000, ctrl, cap, sub};
    endfunction

    task automatic tone_write(input logic [3:0] idx, input logic [7:0] val);
        write_reg({`SND_REG_PSGSEL, 13'd0}, {4'd0, idx});
        write_reg({`SND_REG_PSGDATA, 13'd0}, val);
    endtask

    // Sample table for one page, no repeats so every byte shows on snd
    task automatic fill_page(input logic [7:0] page, input int len);
        logic [7:0] b;
        logic [7:0] last;
        last = 8'h00;
        exp_samp.delete();
        for (int i = 0; i < len; i++) begin
            do b = rand_byte(); while (b == `SND_PCM_END || b == last);
            srom[{page, 8'(i)}] = b;
            exp_samp.push_back(b);
            last = b;
        end
        srom[{page, 8'(len)}] = `SND_PCM_END;
    endtask

    initial begin
        logic [7:0]         shadow [0:255];
        logic [7:0]         offs [$];
        logic [15:0]        a;
        logic [7:0]         v, rd, page;
        logic               err, up;
        logic signed [15:0] prev;
        int                 tgt, pulses, changes;
        rst       = 1;
        psel      = 0;
        penable   = 0;
        pwrite    = 0;
        paddr     = 0;
        pwdata    = 0;
        main_dout = 0;
        m2s_data  = 0;
        repeat (10) @(posedge clk);
        rst <= 0;

        // RAM, ROM and write errors
        for (int i = 0; i < 8; i++) begin
            offs.push_back(rand_byte());
            shadow[offs[i]] = rand_byte();
            write_reg({`SND_REG_RAM, 5'd0, offs[i]}, shadow[offs[i]]);
        end
        foreach (offs[i]) read_check({`SND_REG_RAM, 5'd0, offs[i]}, shadow[offs[i]]);
        for (int i = 0; i < 6; i++) begin
            a = {rand_byte(), rand_byte()} & 16'h3fff;   // ROM codes 0 and 1
            read_check(a, a[7:0] ^ a[15:8]);
        end
        apb_xfer(1, 16'h1234, 8'h55, rd, err);
        assert (err) else report_error("ROM write finished without pslverr");
        apb_xfer(1, {`SND_REG_LATCH, 13'd0}, 8'h55, rd, err);
        assert (err) else report_error("latch write finished without pslverr");

        // Latch, timer, status, unmapped
        v = rand_byte();
        @(posedge clk);
        main_dout <= v;
        m2s_data  <= 1;
        @(posedge clk);
        m2s_data  <= 0;
        read_check({`SND_REG_LATCH, 13'd0}, v);
        read_reg({`SND_REG_TIMER, 13'd0}, rd);
        assert (rd[7:4] == 4'hf) else report_error($sformatf("timer read %h", rd));
        read_reg(io_addr(0, 0, `SND_IO_STAT), rd);
        assert ((rd | 8'h10) == 8'hff) else report_error($sformatf("status read %h", rd));
        for (int s = 5; s < 8; s++) read_check(io_addr(0, 0, 3'(s)), 8'hff);

        // Raw DAC alone, then everything off
        v = rand_byte();
        write_reg(io_addr(0, 0, `SND_IO_RDAC), v);
        write_reg(io_addr(0, 4'b0100, `SND_IO_CAP), 0);
        @(posedge clk);
        repeat (8) begin
            @(posedge clk);
            check_snd($signed(v) * 64, "raw DAC");
        end
        write_reg(io_addr(0, 4'b0000, `SND_IO_CAP), 0);
        repeat (2) @(posedge clk);
        check_snd(0, "all sources gated");

        // Tone channel 0, period 5 and volume 9
        tone_write(0, 5);
        tone_write(1, 0);
        tone_write(6, 9);
        write_reg(io_addr(0, 4'b0001, `SND_IO_CAP), 0);
        while (snd == 0) @(posedge clk);
        prev    = snd;
        pulses  = 0;
        changes = 0;
        while (changes < 8) begin
            @(posedge clk);
            if (psg_cen) pulses++;
            assert (snd == 1152 || snd == -1152) else report_error("tone level off");
            if (snd != prev) begin
                assert (snd == -prev) else report_error("tone did not alternate");
                assert (changes == 0 || pulses == 5)    // First level is partial
                    else report_error($sformatf("tone level lasted %0d pulses", pulses));
                changes++;
                pulses = 0;
                prev   = snd;
            end
        end

        // PCM playback of one page
        page = rand_byte();
        fill_page(page, SAMP_LEN);
        write_reg(io_addr(0, 4'b0010, `SND_IO_CAP), 0);
        write_reg(io_addr(0, 0, `SND_IO_PCMPG), page);
        pcm_mon <= 1;
        write_reg(io_addr(3'b010, 0, `SND_IO_CTRL), 0);   // Reset clear, start
        read_reg(io_addr(0, 0, `SND_IO_STAT), rd);
        assert (rd[4]) else report_error("status busy bit low after PCM start");
        while (rd[4]) read_reg(io_addr(0, 0, `SND_IO_STAT), rd);
        repeat (4) @(posedge clk);
        pcm_mon <= 0;
        assert (seen.size() == SAMP_LEN)
            else report_error($sformatf("%0d PCM samples seen", seen.size()));
        foreach (exp_samp[i])
            assert (seen[i] == $signed(exp_samp[i]) * 64)
                else report_error($sformatf("PCM sample %0d is %0d", i, seen[i]));
        repeat (16) begin
            @(posedge clk);
            check_snd($signed(exp_samp[SAMP_LEN-1]) * 64, "PCM hold");
        end

        // Low-pass toward a DAC step of 128
        v = rand_byte();
        write_reg(io_addr(0, 0, `SND_IO_RDAC), v);
        write_reg(io_addr(0, 4'b0100, `SND_IO_CAP), 0);
        repeat (2) @(posedge clk);
        check_snd($signed(v) * 64, "raw DAC before low-pass");
        write_reg(io_addr(0, 4'b1100, `SND_IO_CAP), 0);
        v   = v ^ 8'h80;
        tgt = $signed(v) * 64;
        write_reg(io_addr(0, 0, `SND_IO_RDAC), v);
        prev = snd;
        up   = tgt > prev;
        repeat (64) begin
            @(posedge clk);
            assert (up ? (snd >= prev && snd <= tgt) : (snd <= prev && snd >= tgt))
                else report_error($sformatf("low-pass step %0d to %0d", prev, snd));
            prev = snd;
        end
        check_snd(tgt, "low-pass final value");

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+verilog
verilog/snd_pkg.sv
verilog/snd_decode.sv
verilog/snd_tone.sv
verilog/snd_pcm.sv
verilog/snd_mix.sv
verilog/snd_top.sv
tb/snd_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = snd_tb
FILELIST  = compile.f
OBJ_DIR   = obj_dir
PASS_MSG  = Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
